//--- laa_bus_pkg.sv
`default_nettype none

// Host side of the accelerator: command encoding and address map
package laa_bus_pkg;

    // Command on the host bus, held for one cycle
    typedef enum logic [1:0] {
        NONE     = 2'd0,  // Idle cycle
        READ     = 2'd1,  // Load read register from addr
        WRITE    = 2'd2,  // Store data_in at addr
        MULTIPLY = 2'd3   // Start C = A x B
    } opcode_t;

    localparam int ADDR_W = 5;   // Command address width
    localparam int DATA_W = 32;  // Write data and read port width

    // Address map
    //   0..8   A, row-major
    //   9..17  B, row-major
    //   18..30 unmapped, commands ignored
    //   31     ready flag, read only
    localparam logic [ADDR_W-1:0] ADDR_A_BASE = 5'd0;   // First A element
    localparam logic [ADDR_W-1:0] ADDR_B_BASE = 5'd9;   // First B element
    localparam logic [ADDR_W-1:0] ADDR_LAST   = 5'd17;  // Last storage address
    localparam logic [ADDR_W-1:0] ADDR_CTRL   = 5'd31;  // Ready flag

endpackage

`default_nettype wire

//--- laa_mat_pkg.sv
`default_nettype none

// Matrix arithmetic: element format and multiply stage numbering
package laa_mat_pkg;

    localparam int MAT_N     = 3;              // Square matrix dimension
    localparam int MAT_ELEMS = MAT_N * MAT_N;  // Elements per matrix

    // Unsigned element, products and sums wrap modulo 2^32
    typedef logic [31:0] elem_t;

    // Stage index, one C element per stage plus the copy-back
    typedef logic [3:0] stage_t;

    localparam stage_t STAGE_IDLE = 4'd0;  // Waiting for MULTIPLY, also computes C[0]
    localparam stage_t STAGE_WB   = 4'd9;  // C copied over A

endpackage

`default_nettype wire

//--- laa_sequencer.sv
`default_nettype none
`timescale 1ns/1ps

// Stage counter for one multiply
//   idle -> 1 -> 2 ... -> 8 -> WB -> idle
// The MULTIPLY edge itself counts as stage 0, so C[0] is taken
// in the same edge that leaves idle
module laa_sequencer (
    input  logic                 bus,     // Clock
    input  logic                 rst,     // Sync reset, active high
    input  laa_bus_pkg::opcode_t opcode,  // Only MULTIPLY matters here
    output laa_mat_pkg::stage_t  stage,   // Current stage index
    output logic                 ready,   // High while idle
    output logic                 wb       // Copy-back cycle
);

    logic start;    // MULTIPLY accepted this edge
    logic running;  // Somewhere in stages 1..WB

    assign start   = ready && (opcode == laa_bus_pkg::MULTIPLY);
    assign running = (stage != laa_mat_pkg::STAGE_IDLE);

    always_ff @(posedge bus) begin
        if (rst) begin
            stage <= laa_mat_pkg::STAGE_IDLE;
        end else if (stage == laa_mat_pkg::STAGE_WB) begin
            stage <= laa_mat_pkg::STAGE_IDLE;  // Done, back to idle
        end else if (start || running) begin
            stage <= stage + laa_mat_pkg::stage_t'(1);  // One C element per clock
        end
    end

    // Both flags decode straight from the counter
    assign ready = (stage == laa_mat_pkg::STAGE_IDLE);
    assign wb    = (stage == laa_mat_pkg::STAGE_WB);

    // Counter never runs past the copy-back stage
    a_stage_range : assert property (
        @(posedge bus) disable iff (rst)
        stage <= laa_mat_pkg::STAGE_WB
    ) else $error("stage %0d beyond copy-back", stage);

    // Copy-back is a single cycle and hands control back to the host
    a_wb_pulse : assert property (
        @(posedge bus) disable iff (rst)
        wb |=> (!wb && ready)
    ) else $error("wb not followed by ready");

endmodule

`default_nettype wire

//--- laa_dot_product.sv
`default_nettype none
`timescale 1ns/1ps

// Row-by-column dot product for the current stage
// Stage s gives C[s] in row-major order, row s/3 and column s%3
// Purely combinational, result is sampled by the register file
module laa_dot_product (
    input  laa_mat_pkg::stage_t stage,                         // Which C element
    input  laa_mat_pkg::elem_t  mat_a [laa_mat_pkg::MAT_ELEMS], // A, row-major
    input  laa_mat_pkg::elem_t  mat_b [laa_mat_pkg::MAT_ELEMS], // B, row-major
    output laa_mat_pkg::elem_t  dot                             // Sum of products, wraps
);

    laa_mat_pkg::stage_t elem;  // Element index, clamped into the C range
    laa_mat_pkg::stage_t col;   // Column of C and of B

    // Operand indices per term
    laa_mat_pkg::stage_t a_idx [laa_mat_pkg::MAT_N];
    laa_mat_pkg::stage_t b_idx [laa_mat_pkg::MAT_N];

    laa_mat_pkg::elem_t prod [laa_mat_pkg::MAT_N];      // Products, low 32 bits
    laa_mat_pkg::elem_t psum [laa_mat_pkg::MAT_N + 1];  // Running sum chain

    // Copy-back stage has no element of its own, point it at C[0]
    assign elem = (stage < laa_mat_pkg::stage_t'(laa_mat_pkg::MAT_ELEMS)) ? stage : '0;

    assign col = elem % laa_mat_pkg::stage_t'(laa_mat_pkg::MAT_N);

    assign psum[0] = '0;

    for (genvar k = 0; k < laa_mat_pkg::MAT_N; k++) begin : g_term
        // elem - col is the first element of the row in A
        assign a_idx[k] = elem - col + laa_mat_pkg::stage_t'(k);
        // Walk down column col of B
        assign b_idx[k] = laa_mat_pkg::stage_t'(k * laa_mat_pkg::MAT_N) + col;

        // Self-determined 32-bit multiply drops the high half
        assign prod[k] = mat_a[a_idx[k]] * mat_b[b_idx[k]];

        assign psum[k + 1] = psum[k] + prod[k];  // Carry out discarded
    end

    assign dot = psum[laa_mat_pkg::MAT_N];

endmodule

`default_nettype wire

//--- laa_regfile.sv
`default_nettype none
`timescale 1ns/1ps

// Element storage and host command decode
//   A and B are host visible, C is internal scratch
//   C fills one element per stage, then wb copies it over A
//   While busy only the ready flag can be read
module laa_regfile (
    input  logic                               bus,       // Clock
    input  logic                               rst,       // Sync reset, active high
    input  laa_bus_pkg::opcode_t               opcode,    // Host command
    input  logic [laa_bus_pkg::ADDR_W-1:0]     addr,      // Host address
    input  logic [laa_bus_pkg::DATA_W-1:0]     data_in,   // Host write data
    output logic [laa_bus_pkg::DATA_W-1:0]     data_out,  // Read register
    input  laa_mat_pkg::stage_t                stage,     // From sequencer
    input  logic                               ready,     // Sequencer idle
    input  logic                               wb,        // Copy C to A this edge
    input  laa_mat_pkg::elem_t                 dot,       // C element for this stage
    output laa_mat_pkg::elem_t                 mat_a [laa_mat_pkg::MAT_ELEMS],
    output laa_mat_pkg::elem_t                 mat_b [laa_mat_pkg::MAT_ELEMS]
);

    laa_mat_pkg::elem_t mat_c [laa_mat_pkg::MAT_ELEMS];  // Product, not addressable

    logic in_a;     // addr hits A
    logic mapped;   // addr hits A or B
    logic host_wr;  // Served WRITE
    logic host_rd;  // Served storage READ
    logic ctrl_rd;  // READ of the ready flag
    logic c_we;     // Store dot into C

    logic [laa_bus_pkg::ADDR_W-1:0]                 offset;    // addr relative to its matrix
    logic [$clog2(laa_mat_pkg::MAT_ELEMS)-1:0]      elem_idx;  // Element within A or B
    laa_mat_pkg::elem_t                             rd_elem;   // Element at addr

    // Address decode
    assign in_a   = (addr < laa_bus_pkg::ADDR_B_BASE);
    assign mapped = (addr <= laa_bus_pkg::ADDR_LAST);
    assign offset = in_a ? (addr - laa_bus_pkg::ADDR_A_BASE)
                         : (addr - laa_bus_pkg::ADDR_B_BASE);
    assign elem_idx = offset[$clog2(laa_mat_pkg::MAT_ELEMS)-1:0];

    assign rd_elem = in_a ? mat_a[elem_idx] : mat_b[elem_idx];

    // Storage access only when idle
    assign host_wr = ready && (opcode == laa_bus_pkg::WRITE) && mapped;
    assign host_rd = ready && (opcode == laa_bus_pkg::READ) && mapped;
    assign ctrl_rd = (opcode == laa_bus_pkg::READ) && (addr == laa_bus_pkg::ADDR_CTRL);

    // Start edge computes C[0], busy stages 1..8 the rest
    assign c_we = (ready && (opcode == laa_bus_pkg::MULTIPLY))
               || (!ready && (stage < laa_mat_pkg::STAGE_WB));

    // A and B
    always_ff @(posedge bus) begin
        if (rst) begin
            for (int i = 0; i < laa_mat_pkg::MAT_ELEMS; i++) begin
                mat_a[i] <= '0;
                mat_b[i] <= '0;
            end
        end else if (wb) begin
            mat_a <= mat_c;  // Result becomes the next left operand
        end else if (host_wr) begin
            if (in_a) begin
                mat_a[elem_idx] <= data_in;
            end else begin
                mat_b[elem_idx] <= data_in;
            end
        end
    end

    // C scratch, every element rewritten before wb reads it
    always_ff @(posedge bus) begin
        if (c_we) begin
            mat_c[stage] <= dot;
        end
    end

    // Read register, holds until the next served READ
    always_ff @(posedge bus) begin
        if (rst) begin
            data_out <= '0;
        end else if (ctrl_rd) begin
            data_out <= {{(laa_bus_pkg::DATA_W - 1){1'b0}}, ready};  // Served even when busy
        end else if (host_rd) begin
            data_out <= rd_elem;
        end
    end

    // Host writes during a multiply leave storage alone
    a_busy_write : assert property (
        @(posedge bus) disable iff (rst)
        (!ready && !wb && (opcode == laa_bus_pkg::WRITE) && mapped)
        |=> (($past(in_a) ? mat_a[$past(elem_idx)] : mat_b[$past(elem_idx)])
             == $past(rd_elem))
    ) else $error("WRITE changed storage while busy");

endmodule

`default_nettype wire

//--- laa.sv
`default_nettype none
`timescale 1ns/1ps

// 3x3 matrix multiply accelerator
// Host writes A and B, issues MULTIPLY, polls address 31, then reads
// the product back from A
module laa (
    input  logic                           bus,       // Clock
    input  logic                           rst,       // Sync reset, active high
    input  laa_bus_pkg::opcode_t           opcode,    // NONE when idle
    input  logic [laa_bus_pkg::ADDR_W-1:0] addr,
    input  logic [laa_bus_pkg::DATA_W-1:0] data_in,
    output logic [laa_bus_pkg::DATA_W-1:0] data_out   // One cycle after READ
);

    laa_mat_pkg::stage_t stage;  // Sequencer state
    logic                ready;  // Idle, host commands accepted
    logic                wb;     // Copy-back pulse
    laa_mat_pkg::elem_t  dot;    // Current C element

    laa_mat_pkg::elem_t mat_a [laa_mat_pkg::MAT_ELEMS];  // A to dot product
    laa_mat_pkg::elem_t mat_b [laa_mat_pkg::MAT_ELEMS];  // B to dot product

    laa_sequencer u_seq (
        .bus    (bus),
        .rst    (rst),
        .opcode (opcode),
        .stage  (stage),
        .ready  (ready),
        .wb     (wb)
    );

    laa_regfile u_regs (
        .bus      (bus),
        .rst      (rst),
        .opcode   (opcode),
        .addr     (addr),
        .data_in  (data_in),
        .data_out (data_out),
        .stage    (stage),
        .ready    (ready),
        .wb       (wb),
        .dot      (dot),
        .mat_a    (mat_a),
        .mat_b    (mat_b)
    );

    laa_dot_product u_dot (
        .stage (stage),
        .mat_a (mat_a),
        .mat_b (mat_b),
        .dot   (dot)
    );

endmodule

`default_nettype wire

//--- tb_laa.sv
`default_nettype none
`timescale 1ns/1ps

module tb_laa;

    logic                                   bus;
    logic                                   rst;
    laa_bus_pkg::opcode_t                   opcode;
    logic [laa_bus_pkg::ADDR_W-1:0]         addr;
    logic [laa_bus_pkg::DATA_W-1:0]         data_in;
    logic [laa_bus_pkg::DATA_W-1:0]         data_out;

    // Golden file contents, one entry per command line
    string       t_name [$];
    string       t_op   [$];
    int          t_addr [$];
    logic [31:0] t_data [$];
    int          t_flag [$];
    logic [31:0] t_exp  [$];

    laa_mat_pkg::elem_t swept [18];  // Random values written by the sweep
    logic [15:0]        lfsr_state;
    int                 cycles = 0;
    int                 cycle_limit = 0;  // Zero until the golden file is loaded

    laa DUT (
        .bus      (bus),
        .rst      (rst),
        .opcode   (opcode),
        .addr     (addr),
        .data_in  (data_in),
        .data_out (data_out)
    );

    initial begin
        bus = 1'b0;
        forever #4 bus = ~bus;  // 8 ns period
    end

    // Watchdog, limit known once the golden file is loaded
    initial begin
        while (cycle_limit == 0 || cycles <= cycle_limit) begin
            @(posedge bus);
            cycles++;
        end
        $display("Test FAILED");
        $fatal(1, "Timeout, run exceeded %0d cycles", cycle_limit);
    end

    // x^16 + x^14 + x^13 + x^11, returns the next state
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // One LFSR step per bit taken
    function automatic logic [31:0] next_random();
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < 32; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    task automatic check_elem(input string name, input laa_mat_pkg::elem_t exp,
                              input laa_mat_pkg::elem_t act);
        if (act !== exp) begin
            $display("error: %s expected %h actual %h", name, exp, act);
            $display("Test FAILED");
            $fatal(1, "Mismatch in %s", name);
        end
    endtask

    task automatic check_ready(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("error: %s expected %0b actual %0b", name, exp, act);
            $display("Test FAILED");
            $fatal(1, "Mismatch in %s", name);
        end
    endtask

    task automatic apply_reset();
        @(posedge bus);
        rst    <= 1'b1;
        opcode <= laa_bus_pkg::NONE;
        repeat (2) @(posedge bus);
        rst    <= 1'b0;
    endtask

    // Command is sampled by the DUT at the following edge
    task automatic drive_cmd(input laa_bus_pkg::opcode_t op, input int a,
                             input logic [31:0] d);
        @(posedge bus);
        opcode  <= op;
        addr    <= a[laa_bus_pkg::ADDR_W-1:0];
        data_in <= d;
    endtask

    // Read result is settled by the falling edge after the sampling edge
    task automatic read_back(input int a);
        drive_cmd(laa_bus_pkg::READ, a, '0);
        @(posedge bus);
        opcode <= laa_bus_pkg::NONE;
        @(negedge bus);
    endtask

    // Flag READ held every cycle, at most 10 sampling edges
    task automatic poll_ready(input string name);
        logic done;
        done = 1'b0;
        drive_cmd(laa_bus_pkg::READ, laa_bus_pkg::ADDR_CTRL, '0);
        for (int i = 0; i < 10 && !done; i++) begin
            @(posedge bus);
            @(negedge bus);
            done = data_out[0];
        end
        if (!done) begin
            $display("Test FAILED");
            $fatal(1, "%s: accelerator never returned to ready", name);
        end
    endtask

    // Every storage address gets an LFSR value, then all are read back
    task automatic sweep_storage();
        for (int a = 0; a <= laa_bus_pkg::ADDR_LAST; a++) begin
            swept[a] = next_random();
            drive_cmd(laa_bus_pkg::WRITE, a, swept[a]);
        end
        for (int a = 0; a <= laa_bus_pkg::ADDR_LAST; a++) begin
            read_back(a);
            check_elem($sformatf("sweep_%0d", a), swept[a], data_out);
        end
    endtask

    task automatic load_golden();
        int    fd;
        int    n;
        string line;
        string name;
        string op;
        int    a;
        int    f;
        logic [31:0] d;
        logic [31:0] e;
        fd = $fopen("laa_golden.txt", "r");
        if (fd == 0) begin
            $display("Test FAILED");
            $fatal(1, "Cannot open golden file laa_golden.txt");
        end
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (n > 0 && line.len() > 1 && line.substr(0, 0) != "#") begin
                if ($sscanf(line, "%s %s %d %h %d %h", name, op, a, d, f, e) == 6) begin
                    t_name.push_back(name);
                    t_op.push_back(op);
                    t_addr.push_back(a);
                    t_data.push_back(d);
                    t_flag.push_back(f);
                    t_exp.push_back(e);
                end
            end
        end
        $fclose(fd);
    endtask

    // Worst-case cycles per command plus a margin
    function automatic int budget();
        int total;
        total = 20 + 3;  // Margin and initial reset
        foreach (t_op[i]) begin
            case (t_op[i])
                "READ":   total += 2;
                "MULT":   total += 10;
                "POLL":   total += 20;
                "SWEEP":  total += 60;
                "RESET":  total += 3;
                default:  total += 1;
            endcase
        end
        return total;
    endfunction

    initial begin
        rst        = 1'b1;  // Held through the first cycles
        opcode     = laa_bus_pkg::NONE;
        addr       = '0;
        data_in    = '0;
        lfsr_state = 16'd75;
        load_golden();
        if (t_op.size() == 0) begin
            $display("Test FAILED");
            $fatal(1, "Golden file holds no commands");
        end
        cycle_limit = budget();
        apply_reset();
        foreach (t_op[i]) begin
            case (t_op[i])
                "WRITE": drive_cmd(laa_bus_pkg::WRITE, t_addr[i], t_data[i]);
                "MULT":  drive_cmd(laa_bus_pkg::MULTIPLY, 0, '0);
                "POLL":  poll_ready(t_name[i]);
                "SWEEP": sweep_storage();
                "RESET": apply_reset();
                "READ": begin
                    read_back(t_addr[i]);
                    if (t_addr[i] == laa_bus_pkg::ADDR_CTRL) begin
                        check_ready(t_name[i], t_exp[i][0], data_out[0]);
                        check_elem(t_name[i], {31'b0, t_exp[i][0]}, data_out);  // Zero-extended
                    end else if (t_flag[i] == 1) begin
                        check_elem(t_name[i], t_exp[i], data_out);
                    end else if (t_flag[i] == 2) begin
                        check_elem(t_name[i], swept[t_addr[i]], data_out);
                    end
                end
                default: begin
                    $display("Test FAILED");
                    $fatal(1, "Unknown command %s in golden file", t_op[i]);
                end
            endcase
        end
        @(posedge bus);
        opcode <= laa_bus_pkg::NONE;
        $display("Test OK");
        $finish;
    end

endmodule

`default_nettype wire

//--- laa_golden.txt
# name op addr(decimal) data(hex) flag expected(hex)
# flag 0 no check, 1 compare with expected, 2 compare with the random value last swept into addr
rst_ready READ 31 0 1 1
rst_a0 READ 0 0 1 0
rst_a8 READ 8 0 1 0
rst_b17 READ 17 0 1 0
sweep SWEEP 0 0 0 0
unmapped_w18 WRITE 18 deadbeef 0 0
unmapped_w30 WRITE 30 deadbeef 0 0
unmapped_a0 READ 0 0 2 0
clear RESET 0 0 0 0
ident_a0 WRITE 0 1 0 0
ident_a1 WRITE 1 2 0 0
ident_a2 WRITE 2 3 0 0
ident_a3 WRITE 3 4 0 0
ident_a4 WRITE 4 5 0 0
ident_a5 WRITE 5 6 0 0
ident_a6 WRITE 6 7 0 0
ident_a7 WRITE 7 8 0 0
ident_a8 WRITE 8 9 0 0
ident_b9 WRITE 9 1 0 0
ident_b13 WRITE 13 1 0 0
ident_b17 WRITE 17 1 0 0
ident_mult MULT 0 0 0 0
busy_flag READ 31 0 1 0
ident_poll POLL 31 0 0 0
ident_c0 READ 0 0 1 1
ident_c1 READ 1 0 1 2
ident_c2 READ 2 0 1 3
ident_c3 READ 3 0 1 4
ident_c4 READ 4 0 1 5
ident_c5 READ 5 0 1 6
ident_c6 READ 6 0 1 7
ident_c7 READ 7 0 1 8
ident_c8 READ 8 0 1 9
small_b9 WRITE 9 2 0 0
small_b13 WRITE 13 2 0 0
small_b17 WRITE 17 2 0 0
small_mult MULT 0 0 0 0
small_poll POLL 31 0 0 0
small_c0 READ 0 0 1 2
small_c1 READ 1 0 1 4
small_c2 READ 2 0 1 6
small_c3 READ 3 0 1 8
small_c4 READ 4 0 1 a
small_c5 READ 5 0 1 c
small_c6 READ 6 0 1 e
small_c7 READ 7 0 1 10
small_c8 READ 8 0 1 12
chain_mult MULT 0 0 0 0
chain_lock WRITE 13 7 0 0
chain_poll POLL 31 0 0 0
chain_c0 READ 0 0 1 4
chain_c1 READ 1 0 1 8
chain_c2 READ 2 0 1 c
chain_c3 READ 3 0 1 10
chain_c4 READ 4 0 1 14
chain_c5 READ 5 0 1 18
chain_c6 READ 6 0 1 1c
chain_c7 READ 7 0 1 20
chain_c8 READ 8 0 1 24
chain_b9 READ 9 0 1 2
chain_b13 READ 13 0 1 2
chain_b17 READ 17 0 1 2
chain_b10 READ 10 0 1 0
wrap_a0 WRITE 0 80000001 0 0
wrap_a1 WRITE 1 ffffffff 0 0
wrap_b10 WRITE 10 1 0 0
wrap_mult MULT 0 0 0 0
wrap_poll POLL 31 0 0 0
wrap_c0 READ 0 0 1 2
wrap_c1 READ 1 0 1 7fffffff
wrap_c2 READ 2 0 1 18
wrap_c3 READ 3 0 1 20
wrap_c4 READ 4 0 1 38
wrap_c5 READ 5 0 1 30
wrap_c6 READ 6 0 1 38
wrap_c7 READ 7 0 1 5c
wrap_c8 READ 8 0 1 48

//--- all.f
laa_bus_pkg.sv
laa_mat_pkg.sv
laa_sequencer.sv
laa_dot_product.sv
laa_regfile.sv
laa.sv
tb_laa.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_laa
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
PASS_MSG  ?= Test OK

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "^$(PASS_MSG)$$"

clean:
	rm -rf $(OBJ_DIR)
